// ==== trig_gen.f ====
hw/trig_pkg.sv
hw/trig_ch_if.sv
hw/trig_cmd_decoder.sv
hw/trig_pulse_out.sv
hw/trig_top.sv
tests/trig_assert.sv
tests/trig_tb.sv

// ==== Makefile ====
# Verilator build and run for the trigger pulse generator.

VERILATOR  ?= verilator
TOP        ?= trig_tb
FLIST      ?= trig_gen.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Simulation PASSED

SIM = $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	@out="$$($(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/trig_tb.sv ====
`timescale 1ns/1ps

module trig_tb;
    import trig_pkg::*;

    localparam int NUM_CH = 2;
    localparam int MS_CLKS = 4;
    localparam int RESET_SLOT_MS = 500;
    localparam int WAIT_MAX = 20000; // Cycles per wait.

    logic              clk;
    logic              rst;
    logic              cmd_valid;
    logic [CMD_W-1:0]  cmd_data;
    logic              cmd_ready;
    logic [NUM_CH-1:0] pin;
    logic [NUM_CH-1:0] busy;
    logic [NUM_CH-1:0] done;

    // Expected state of each channel, taken at its fire handshake.
    bit         act [NUM_CH];
    int         hs_cyc [NUM_CH];
    trig_mode_t r_mode [NUM_CH];
    int         r_delay [NUM_CH];
    int         r_slot [NUM_CH];

    int          cur_slot;
    int          cyc = 0;
    int          err_pin;
    int          err_flag;
    logic [31:0] rng;
    bit          aborted = 1'b0;
    string       abort_why;

    trig_top #(
        .NUM_CH(NUM_CH),
        .MS_CLKS(MS_CLKS)
    ) trig_top_i (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_data(cmd_data),
        .cmd_ready(cmd_ready),
        .pin(pin),
        .busy(busy),
        .done(done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int rand_below(input int n);
        rng = xorshift(rng);
        return int'(rng % n);
    endfunction

    // Mask built from the high, low, high run lengths of each mode.
    function automatic logic [7:0] ref_mask(input trig_mode_t m);
        logic [2:0] h1;
        logic [2:0] l1;
        logic [2:0] h2;
        logic [7:0] mk;
        case (m)
            3'd0: {h1, l1, h2} = {3'd1, 3'd1, 3'd0};
            3'd1: {h1, l1, h2} = {3'd1, 3'd1, 3'd1};
            3'd2: {h1, l1, h2} = {3'd2, 3'd2, 3'd0};
            3'd3: {h1, l1, h2} = {3'd2, 3'd2, 3'd2};
            3'd4: {h1, l1, h2} = {3'd1, 3'd1, 3'd2};
            3'd5: {h1, l1, h2} = {3'd1, 3'd2, 3'd1};
            3'd6: {h1, l1, h2} = {3'd2, 3'd1, 3'd2};
            default: {h1, l1, h2} = {3'd4, 3'd4, 3'd0};
        endcase
        mk = '0;
        for (int i = 0; i < h1; i++) mk[3'(i)] = 1'b1;
        for (int i = 0; i < h2; i++) mk[3'(h1 + l1 + i)] = 1'b1;
        return mk;
    endfunction

    function automatic int done_at(input int d, input int l);
        return 2 + (d + 8 * l) * MS_CLKS;
    endfunction

    // Returns pin, busy and done k cycles after the fire handshake.
    function automatic logic [2:0] ref_out(input trig_mode_t m, input int d, input int l,
                                           input int k);
        int         slot0;
        int         dk;
        int         idx;
        logic [7:0] mk;
        logic       p;
        mk    = ref_mask(m);
        slot0 = 2 + d * MS_CLKS;
        dk    = done_at(d, l);
        p     = 1'b0;
        if (k >= slot0 && k < dk) begin
            idx = (k - slot0) / (l * MS_CLKS);
            p   = mk[3'(idx)];
        end
        return {p, (k >= 1 && k <= dk), (k == dk)};
    endfunction

    // A channel blocks new words from its handshake up to its done cycle.
    function automatic logic occupied(input int c);
        int k;
        k = cyc - hs_cyc[c];
        return act[c] && k >= 0 && k <= done_at(r_delay[c], r_slot[c]);
    endfunction

    function automatic logic exp_ready(input trig_cmd_u w);
        logic r;
        r = 1'b1;
        if (w.cfg.op) begin
            for (int c = 0; c < NUM_CH; c++) begin
                if (occupied(c)) r = 1'b0;
            end
        end else if (int'(w.fire.ch) < NUM_CH) begin
            r = !occupied(int'(w.fire.ch));
        end
        return r;
    endfunction

    function automatic trig_cmd_u make_fire(input int c, input trig_mode_t m, input int d);
        trig_cmd_u w;
        w.fire.op       = 1'b0;
        w.fire.ch       = 2'(c);
        w.fire.mode     = m;
        w.fire.delay_ms = DELAY_W'(d);
        return w;
    endfunction

    function automatic trig_cmd_u make_cfg(input int s);
        trig_cmd_u w;
        w.cfg.op      = 1'b1;
        w.cfg.rsvd    = '0;
        w.cfg.slot_ms = SLOT_W'(s);
        return w;
    endfunction

    task automatic check_pin(input string name, input logic [NUM_CH-1:0] got,
                             input logic [NUM_CH-1:0] exp);
        if (got !== exp) begin
            err_pin++;
            $display("** Error: %s = 0x%h, expected 0x%h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            err_flag++;
            $display("** Error: %s = 0x%h, expected 0x%h at cycle %0d", name, got, exp, cyc);
        end
    endtask

    // Stops this process for good and hands the failure to the watcher.
    task automatic give_up(input string why);
        abort_why = why;
        aborted   = 1'b1;
        wait (!aborted);
    endtask

    // Called right after a rising edge, returns right after the transfer edge.
    task automatic send_word(input trig_cmd_u w);
        int n;
        bit got;
        int c;
        n   = 0;
        got = 1'b0;
        cmd_valid <= 1'b1;
        cmd_data  <= w;
        while (!got) begin
            @(negedge clk);
            check_flag("cmd_ready", cmd_ready, exp_ready(w));
            if (cmd_ready) begin
                got = 1'b1;
            end else begin
                n++;
                if (n > WAIT_MAX) give_up("Timeout: a command word was never accepted.");
            end
        end
        if (w.cfg.op) begin
            cur_slot = (w.cfg.slot_ms == '0) ? 1 : int'(w.cfg.slot_ms);
        end else if (int'(w.fire.ch) < NUM_CH) begin
            c          = int'(w.fire.ch);
            act[c]     = 1'b1;
            hs_cyc[c]  = cyc + 1; // The transfer edge comes next.
            r_mode[c]  = w.fire.mode;
            r_delay[c] = int'(w.fire.delay_ms);
            r_slot[c]  = cur_slot;
        end
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    task automatic wait_done(input logic [NUM_CH-1:0] which);
        int                n;
        logic [NUM_CH-1:0] seen;
        n    = 0;
        seen = '0;
        while ((seen & which) != which) begin
            @(negedge clk);
            seen = seen | done;
            n++;
            if (n > WAIT_MAX) give_up("Timeout: a channel never signalled done.");
        end
        @(posedge clk);
    endtask

    // Compares every output against the reference once per cycle.
    always @(negedge clk) begin : monitor
        logic [2:0]        r;
        logic [NUM_CH-1:0] ep;
        if (!rst) begin
            for (int c = 0; c < NUM_CH; c++) begin
                r = act[c] ? ref_out(r_mode[c], r_delay[c], r_slot[c], cyc - hs_cyc[c]) : 3'b0;
                ep[c] = r[2];
                check_flag($sformatf("busy[%0d]", c), busy[c], r[1]);
                check_flag($sformatf("done[%0d]", c), done[c], r[0]);
            end
            check_pin("pin", pin, ep);
        end
    end

    initial begin : watcher
        wait (aborted);
        $display("%s", abort_why);
        $display("Simulation FAILED");
        $finish;
    end

    initial begin
        int         d;
        trig_mode_t m;
        rst       = 1'b1;
        cmd_valid = 1'b0;
        cmd_data  = '0;
        cur_slot  = RESET_SLOT_MS;
        rng       = 32'hd8ef;
        err_pin   = 0;
        err_flag  = 0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Reset state with the default slot length.
        send_word(make_fire(0, 3'd0, 0));
        wait_done(2'b01);

        send_word(make_cfg(2));
        for (int i = 0; i < 8; i++) begin
            send_word(make_fire(0, trig_mode_t'(i), 0));
            wait_done(2'b01);
        end

        // Fixed small delays first, then random ones.
        for (int i = 0; i < 8; i++) begin
            d = (i < 4) ? i : rand_below(12);
            m = trig_mode_t'(rand_below(8));
            send_word(make_fire(0, m, d));
            wait_done(2'b01);
        end

        // Both words stall until the running sequence is done.
        send_word(make_fire(0, 3'd3, 2));
        send_word(make_fire(0, 3'd1, 0));
        send_word(make_cfg(1));

        for (int i = 0; i < 3; i++) begin
            send_word(make_fire(0, trig_mode_t'(rand_below(8)), rand_below(6)));
            send_word(make_fire(1, trig_mode_t'(rand_below(8)), rand_below(6)));
            wait_done(2'b11);
        end

        // Zero slot length and a channel that does not exist.
        send_word(make_cfg(0));
        send_word(make_fire(3, 3'd6, 1));
        send_word(make_fire(0, 3'd6, 1));
        wait_done(2'b01);
        repeat (4) @(posedge clk);

        $display("Checks done: %0d pin errors, %0d flag errors", err_pin, err_flag);
        if (err_pin == 0 && err_flag == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== tests/trig_assert.sv ====
`timescale 1ns/1ps

module trig_pulse_out_assert (
    input logic clk,
    input logic rst,
    input logic start,
    input logic busy,
    input logic done,
    input logic pin
);

    // The pin only moves inside a running sequence.
    pin_low_when_idle: assert property (@(posedge clk) disable iff (rst) !busy |-> !pin)
        else $error("pin is high while the channel is idle");

    // Done closes a busy period and busy drops right after it.
    done_ends_busy: assert property (@(posedge clk) disable iff (rst)
        done |-> $past(busy) ##1 !busy)
        else $error("done did not close a busy period");

    done_one_cycle: assert property (@(posedge clk) disable iff (rst) done |=> !done)
        else $error("done is longer than one cycle");

    start_when_idle: assert property (@(posedge clk) disable iff (rst) start |-> !busy)
        else $error("start arrived while the channel was busy");

endmodule

bind trig_pulse_out trig_pulse_out_assert assert_i (
    .clk(clk),
    .rst(rst),
    .start(ch.start),
    .busy(ch.busy),
    .done(ch.done),
    .pin(pin)
);

// ==== hw/trig_top.sv ====
`timescale 1ns/1ps

module trig_top #(
    parameter int NUM_CH  = 2,
    parameter int MS_CLKS = 75000
) (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cmd_valid,
    input  logic [trig_pkg::CMD_W-1:0] cmd_data,
    output logic                       cmd_ready,
    output logic [NUM_CH-1:0]          pin,
    output logic [NUM_CH-1:0]          busy,
    output logic [NUM_CH-1:0]          done
);

    trig_ch_if ch_if [NUM_CH] ();

    trig_cmd_decoder #(
        .NUM_CH(NUM_CH)
    ) decoder_i (
        .clk(clk),
        .rst(rst),
        .cmd_valid(cmd_valid),
        .cmd_data(cmd_data),
        .cmd_ready(cmd_ready),
        .ch(ch_if)
    );

    // One pulse generator per channel.
    for (genvar i = 0; i < NUM_CH; i++) begin : g_out
        trig_pulse_out #(
            .MS_CLKS(MS_CLKS)
        ) out_i (
            .clk(clk),
            .rst(rst),
            .ch(ch_if[i]),
            .pin(pin[i])
        );

        assign busy[i] = ch_if[i].busy;
        assign done[i] = ch_if[i].done;
    end

endmodule

// ==== hw/trig_pulse_out.sv ====
`timescale 1ns/1ps

module trig_pulse_out #(
    parameter int MS_CLKS = 75000
) (
    input  logic    clk,
    input  logic    rst,
    trig_ch_if.chan ch,
    output logic    pin
);
    import trig_pkg::*;

    localparam logic [1:0] IDLE  = 2'd0;
    localparam logic [1:0] DELAY = 2'd1;
    localparam logic [1:0] SLOT  = 2'd2;
    localparam logic [1:0] DONE  = 2'd3;

    localparam int PRE_W = (MS_CLKS > 1) ? $clog2(MS_CLKS) : 1;
    localparam int IDX_W = $clog2(NUM_SLOTS);

    logic [1:0]           state;
    logic [1:0]           next_state;
    logic [PRE_W-1:0]     pre_cnt;   // Clocks within the current ms.
    logic [SLOT_W-1:0]    ms_cnt;
    logic [SLOT_W-1:0]    ms_target;
    logic [IDX_W-1:0]     slot_idx;
    logic [NUM_SLOTS-1:0] mask;
    logic                 running;
    logic                 ms_tick;
    logic                 ms_last;
    logic                 last_slot;
    logic                 done_r;

    assign running   = (state == DELAY) || (state == SLOT);
    assign ms_tick   = (pre_cnt == PRE_W'(MS_CLKS - 1));
    assign ms_target = (state == DELAY) ? SLOT_W'(ch.delay_ms) : ch.slot_ms;
    assign ms_last   = ms_tick && (ms_cnt == ms_target - 1'b1); // End of delay or slot.
    assign last_slot = (slot_idx == IDX_W'(NUM_SLOTS - 1));
    assign mask      = mode_mask(ch.mode);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE: begin
                if (ch.start) begin
                    // No delay means the first slot starts right away.
                    next_state = (ch.delay_ms == '0) ? SLOT : DELAY;
                end
            end
            DELAY: begin
                if (ms_last) begin
                    next_state = SLOT;
                end
            end
            SLOT: begin
                if (ms_last && last_slot) begin
                    next_state = DONE;
                end
            end
            DONE: next_state = IDLE;
            default: next_state = IDLE;
        endcase
    end

    // Millisecond prescaler.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pre_cnt <= '0;
        end else if (!running || ms_tick) begin
            pre_cnt <= '0;
        end else begin
            pre_cnt <= pre_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ms_cnt <= '0;
        end else if (!running || ms_last) begin
            ms_cnt <= '0;
        end else if (ms_tick) begin
            ms_cnt <= ms_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_idx <= '0;
        end else if (state != SLOT) begin
            slot_idx <= '0;
        end else if (ms_last && !last_slot) begin
            slot_idx <= slot_idx + 1'b1;
        end
    end

    // Pin and done trail the state by one clock.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pin    <= 1'b0;
            done_r <= 1'b0;
        end else begin
            pin    <= (state == SLOT) && mask[slot_idx];
            done_r <= (state == DONE);
        end
    end

    assign ch.done = done_r;
    assign ch.busy = (state != IDLE) || done_r; // Held through the done cycle.

endmodule

// ==== hw/trig_cmd_decoder.sv ====
`timescale 1ns/1ps

module trig_cmd_decoder #(
    parameter int NUM_CH = 2
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_valid,
    input  trig_pkg::trig_cmd_u cmd_data,
    output logic                cmd_ready,
    trig_ch_if.ctrl             ch [NUM_CH]
);
    import trig_pkg::*;

    logic [NUM_CH-1:0] ch_busy; // Busy, or a start still on its way.
    logic [SLOT_W-1:0] slot_ms_r;
    logic              is_cfg;
    logic              accept;
    logic              fire_hs;
    logic              cfg_hs;

    assign is_cfg = cmd_data.cfg.op;

    // Config waits for every channel, a fire only for its own one.
    always_comb begin
        cmd_ready = 1'b1;
        if (is_cfg) begin
            cmd_ready = ~|ch_busy;
        end else begin
            for (int i = 0; i < NUM_CH; i++) begin
                if (cmd_data.fire.ch == 2'(i)) begin
                    cmd_ready = ~ch_busy[i];
                end
            end
        end
    end

    assign accept  = cmd_valid && cmd_ready;
    assign fire_hs = accept && !is_cfg;
    assign cfg_hs  = accept && is_cfg;

    // Shared slot length. A zero is taken as 1 ms.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_ms_r <= DEF_SLOT_MS;
        end else if (cfg_hs) begin
            if (cmd_data.cfg.slot_ms == '0) begin
                slot_ms_r <= SLOT_W'(1);
            end else begin
                slot_ms_r <= cmd_data.cfg.slot_ms;
            end
        end
    end

    for (genvar i = 0; i < NUM_CH; i++) begin : g_ch
        logic               sel;
        logic               start_q;
        trig_mode_t         mode_q;
        logic [DELAY_W-1:0] delay_q;

        assign sel = fire_hs && (cmd_data.fire.ch == 2'(i));

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                start_q <= 1'b0;
            end else begin
                start_q <= sel; // Start in the cycle after the handshake.
            end
        end

        always_ff @(posedge clk) begin
            if (sel) begin
                mode_q  <= cmd_data.fire.mode;
                delay_q <= cmd_data.fire.delay_ms;
            end
        end

        assign ch_busy[i]     = ch[i].busy | start_q;
        assign ch[i].start    = start_q;
        assign ch[i].mode     = mode_q;
        assign ch[i].delay_ms = delay_q;
        assign ch[i].slot_ms  = slot_ms_r;
    end

endmodule

// ==== hw/trig_ch_if.sv ====
`timescale 1ns/1ps

interface trig_ch_if;
    import trig_pkg::*;

    logic               start; // One cycle pulse from the decoder.
    trig_mode_t         mode;
    logic [DELAY_W-1:0] delay_ms;
    logic [SLOT_W-1:0]  slot_ms;
    logic               busy;
    logic               done;

    modport ctrl (
        output start,
        output mode,
        output delay_ms,
        output slot_ms,
        input  busy,
        input  done
    );

    modport chan (
        input  start,
        input  mode,
        input  delay_ms,
        input  slot_ms,
        output busy,
        output done
    );

endinterface

// ==== hw/trig_pkg.sv ====
package trig_pkg;

    localparam int CMD_W = 16;
    localparam int DELAY_W = 10; // Delay in ms, 0 to 1023.
    localparam int SLOT_W = 12;
    localparam int NUM_SLOTS = 8;

    localparam logic [SLOT_W-1:0] DEF_SLOT_MS = 12'd500;

    typedef logic [2:0] trig_mode_t;

    // Fire view of a command word.
    typedef struct packed {
        logic               op; // 0 for fire.
        logic [1:0]         ch;
        trig_mode_t         mode;
        logic [DELAY_W-1:0] delay_ms;
    } trig_fire_t;

    // Config view of a command word.
    typedef struct packed {
        logic              op; // 1 for config.
        logic [2:0]        rsvd;
        logic [SLOT_W-1:0] slot_ms;
    } trig_cfg_t;

    typedef union packed {
        trig_fire_t fire;
        trig_cfg_t  cfg;
    } trig_cmd_u;

    // Bit i is the pin level during slot i.
    function automatic logic [NUM_SLOTS-1:0] mode_mask(input trig_mode_t mode);
        logic [NUM_SLOTS-1:0] mask;
        case (mode)
            3'd0: mask = 8'h01; // 1 high, 1 low.
            3'd1: mask = 8'h05;
            3'd2: mask = 8'h03;
            3'd3: mask = 8'h33;
            3'd4: mask = 8'h0D;
            3'd5: mask = 8'h09;
            3'd6: mask = 8'h1B;
            3'd7: mask = 8'h0F; // 4 high, 4 low.
            default: mask = '0;
        endcase
        return mask;
    endfunction

endpackage
